// ==== design/bpPkg.sv ====
// Shared widths, opcodes and reset constants of the fetch predictor
// Packed record types passed between the predictor units
package bpPkg;

    // Machine word and fetch PC reset value
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] PC_START = '0;

    // Branch target buffer geometry
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_BITS = XLEN - BTB_IDX_BITS - 2;

    // History length and pattern table size
    localparam int GHR_BITS = 5;
    localparam int PHT_ENTRIES = 2 ** GHR_BITS;

    // RV32I opcodes seen by the predictor
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Weakly not taken
    localparam logic [1:0] CNT_RESET = 2'b01;

    typedef logic [XLEN-1:0] pcT;
    typedef logic [XLEN-1:0] instrT;
    typedef logic [GHR_BITS-1:0] ghrT;
    typedef logic [BTB_IDX_BITS-1:0] btbIdxT;
    typedef logic [BTB_TAG_BITS-1:0] btbTagT;

    // Prediction record carried down the pipe
    typedef struct packed {
        logic valid;
        logic taken;
        pcT pc;
        ghrT phtIdx;
    } predT;

    // Execute-stage facts supplied by the rest of the core
    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        logic zero;
        pcT imm;
    } exInfoT;

    // BTB fill from execute
    typedef struct packed {
        logic we;
        btbIdxT idx;
        btbTagT tag;
        pcT target;
    } btbWriteT;

    // Counter update from execute
    typedef struct packed {
        logic we;
        logic inc;
        ghrT idx;
    } phtUpdateT;

endpackage

// ==== design/btb.sv ====
// Direct-mapped branch target buffer
// Combinational lookup, one write per cycle from execute
`timescale 1ns/10ps

module btb import bpPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pcT       lookupPc_i,
    output logic     hit_o,
    output pcT       target_o,
    input  btbWriteT write_i
);

    // Per-entry state
    logic   validQ [BTB_ENTRIES];
    btbTagT tagQ [BTB_ENTRIES];
    pcT     targetQ [BTB_ENTRIES];

    btbIdxT lookupIdx;
    btbTagT lookupTag;

    // Index from PC bits above the byte offset, tag from the rest
    assign lookupIdx = lookupPc_i[BTB_IDX_BITS+1:2];
    assign lookupTag = lookupPc_i[XLEN-1:BTB_IDX_BITS+2];

    always_comb begin
        hit_o = validQ[lookupIdx] && (tagQ[lookupIdx] == lookupTag);
        target_o = targetQ[lookupIdx];
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                validQ[i] <= 1'b0;
            end
        end else if (write_i.we) begin
            validQ[write_i.idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (write_i.we) begin
            tagQ[write_i.idx] <= write_i.tag;
            targetQ[write_i.idx] <= write_i.target;
        end
    end

    // Learned targets must be word aligned, fetch never sees a half address
    targetAligned: assert property (
        @(posedge clk) disable iff (reset)
        write_i.we |-> (write_i.target[1:0] == 2'b00)
    ) else $error("BTB written with misaligned target %h", write_i.target);

endmodule

// ==== design/globalHistory.sv ====
// Global history register and pattern history table
// 2-bit saturating counters indexed by the current history
`timescale 1ns/10ps

module globalHistory import bpPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      shift_i,
    input  logic      shiftBit_i,
    input  logic      clear_i,
    output ghrT       phtIdx_o,
    output logic      counterHigh_o,
    input  phtUpdateT update_i
);

    ghrT ghrQ;
    ghrT ghrNext;
    logic [1:0] phtQ [PHT_ENTRIES];
    logic [1:0] oldCount;

    // History is the table index, no hashing with the PC
    assign phtIdx_o = ghrQ;
    assign counterHigh_o = phtQ[ghrQ][1];

    // Clear on mispredict wins over a fetch shift
    always_comb begin
        if (clear_i) begin
            ghrNext = '0;
        end else if (shift_i) begin
            ghrNext = {ghrQ[GHR_BITS-2:0], shiftBit_i};
        end else begin
            ghrNext = ghrQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ghrQ <= '0;
        end else begin
            ghrQ <= ghrNext;
        end
    end

    assign oldCount = phtQ[update_i.idx];

    // Counter update with saturation at both ends
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                phtQ[i] <= CNT_RESET;
            end
        end else if (update_i.we) begin
            if (update_i.inc && oldCount != 2'b11) begin
                phtQ[update_i.idx] <= oldCount + 2'b01;
            end else if (!update_i.inc && oldCount != 2'b00) begin
                phtQ[update_i.idx] <= oldCount - 2'b01;
            end
        end
    end

endmodule

// ==== design/branchResolve.sv ====
// Fetch prediction record, decode and execute prediction slots
// Branch outcome check, mispredict redirect and predictor update commands
`timescale 1ns/10ps

module branchResolve import bpPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  instrT     instrF_i,
    input  pcT        pcF_i,
    input  logic      stallF_i,
    input  logic      stallD_i,
    input  logic      flushD_i,
    input  logic      flushE_i,
    input  logic      btbHit_i,
    input  ghrT       phtIdx_i,
    input  logic      counterHigh_i,
    input  exInfoT    exInfo_i,
    output logic      predTaken_o,
    output logic      ghrShift_o,
    output logic      mispredict_o,
    output pcT        redirectPc_o,
    output btbWriteT  btbWrite_o,
    output phtUpdateT phtUpdate_o
);

    logic isBranchF;
    logic isJumpF;
    predT fetchRec;
    predT decQ;
    predT exQ;
    logic isBranchE;
    logic isJumpE;
    logic actualTaken;
    pcT   targetE;

    // Fetch side, opcode decode of the raw instruction word
    assign isBranchF = (instrF_i[6:0] == OP_BRANCH);
    assign isJumpF = (instrF_i[6:0] == OP_JAL) || (instrF_i[6:0] == OP_JALR);

    // Jumps always taken on a hit, branches follow the counter
    assign predTaken_o = btbHit_i && (isJumpF || (isBranchF && counterHigh_i));
    assign ghrShift_o = !stallF_i && isBranchF;

    always_comb begin
        fetchRec.valid = 1'b1;
        fetchRec.taken = predTaken_o;
        fetchRec.pc = pcF_i;
        fetchRec.phtIdx = phtIdx_i;
    end

    // Decode slot
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            decQ.valid <= 1'b0;
        end else if (!stallD_i) begin
            decQ <= fetchRec;
        end
    end

    // Execute slot, no stall here
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            exQ.valid <= 1'b0;
        end else begin
            exQ <= decQ;
        end
    end

    // Outcome of the instruction in execute
    assign isBranchE = (exInfo_i.op == OP_BRANCH);
    assign isJumpE = (exInfo_i.op == OP_JAL) || (exInfo_i.op == OP_JALR);
    assign actualTaken = isBranchE &&
        ((exInfo_i.funct3 == F3_BEQ && exInfo_i.zero) ||
         (exInfo_i.funct3 == F3_BNE && !exInfo_i.zero));
    assign targetE = exQ.pc + exInfo_i.imm;

    assign mispredict_o = exQ.valid &&
        ((isBranchE && (exQ.taken != actualTaken)) || (isJumpE && !exQ.taken));

    // Predicted taken but wrong means fall through
    assign redirectPc_o = exQ.taken ? exQ.pc + 32'd4 : targetE;

    always_comb begin
        btbWrite_o.we = exQ.valid && (actualTaken || isJumpE);
        btbWrite_o.idx = exQ.pc[BTB_IDX_BITS+1:2];
        btbWrite_o.tag = exQ.pc[XLEN-1:BTB_IDX_BITS+2];
        btbWrite_o.target = targetE;
        phtUpdate_o.we = exQ.valid && isBranchE;
        phtUpdate_o.inc = actualTaken;
        phtUpdate_o.idx = exQ.phtIdx;
    end

endmodule

// ==== design/fetchPc.sv ====
// Fetch program counter and next-PC selection
`timescale 1ns/10ps

module fetchPc import bpPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stallF_i,
    input  logic predTaken_i,
    input  pcT   predTarget_i,
    input  logic mispredict_i,
    input  pcT   redirectPc_i,
    output pcT   pcF_o
);

    pcT pcQ;
    pcT pcNext;

    assign pcF_o = pcQ;

    // Redirect first, then BTB prediction, then sequential
    always_comb begin
        if (mispredict_i) begin
            pcNext = redirectPc_i;
        end else if (predTaken_i) begin
            pcNext = predTarget_i;
        end else begin
            pcNext = pcQ + 32'd4;
        end
    end

    // A redirect moves the PC even when fetch is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pcQ <= PC_START;
        end else if (mispredict_i || !stallF_i) begin
            pcQ <= pcNext;
        end
    end

    // Targets from BTB and execute must keep fetch word aligned
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pcF_o[1:0] == 2'b00
    ) else $error("Fetch PC misaligned: %h", pcF_o);

endmodule

// ==== design/bpFrontEnd.sv ====
// Branch prediction fetch front end
// PC, BTB, global history predictor and execute-stage resolution
`timescale 1ns/10ps

module bpFrontEnd import bpPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instrT  instrF_i,
    input  logic   stallF_i,
    input  logic   stallD_i,
    input  logic   flushD_i,
    input  logic   flushE_i,
    input  exInfoT exInfo_i,
    output pcT     pcF_o,
    output logic   predTakenF_o,
    output logic   mispredict_o
);

    logic      btbHit;
    pcT        btbTarget;
    ghrT       phtIdx;
    logic      counterHigh;
    logic      ghrShift;
    pcT        redirectPc;
    btbWriteT  btbWrite;
    phtUpdateT phtUpdate;

    fetchPc uFetchPc (
        .clk          (clk),
        .reset        (reset),
        .stallF_i     (stallF_i),
        .predTaken_i  (predTakenF_o),
        .predTarget_i (btbTarget),
        .mispredict_i (mispredict_o),
        .redirectPc_i (redirectPc),
        .pcF_o        (pcF_o)
    );

    btb uBtb (
        .clk        (clk),
        .reset      (reset),
        .lookupPc_i (pcF_o),
        .hit_o      (btbHit),
        .target_o   (btbTarget),
        .write_i    (btbWrite)
    );

    // History shifts in the fetch prediction, clears on mispredict
    globalHistory uGlobalHistory (
        .clk           (clk),
        .reset         (reset),
        .shift_i       (ghrShift),
        .shiftBit_i    (predTakenF_o),
        .clear_i       (mispredict_o),
        .phtIdx_o      (phtIdx),
        .counterHigh_o (counterHigh),
        .update_i      (phtUpdate)
    );

    branchResolve uBranchResolve (
        .clk           (clk),
        .reset         (reset),
        .instrF_i      (instrF_i),
        .pcF_i         (pcF_o),
        .stallF_i      (stallF_i),
        .stallD_i      (stallD_i),
        .flushD_i      (flushD_i),
        .flushE_i      (flushE_i),
        .btbHit_i      (btbHit),
        .phtIdx_i      (phtIdx),
        .counterHigh_i (counterHigh),
        .exInfo_i      (exInfo_i),
        .predTaken_o   (predTakenF_o),
        .ghrShift_o    (ghrShift),
        .mispredict_o  (mispredict_o),
        .redirectPc_o  (redirectPc),
        .btbWrite_o    (btbWrite),
        .phtUpdate_o   (phtUpdate)
    );

endmodule

// ==== dv/bpModel.svh ====
// Reference model of the fetch predictor
// PC, BTB, GHR, PHT and the decode and execute prediction slots
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

pcT         mPc;
logic       mBtbValid [BTB_ENTRIES];
btbTagT     mBtbTag [BTB_ENTRIES];
pcT         mBtbTarget [BTB_ENTRIES];
ghrT        mGhr;
logic [1:0] mPht [PHT_ENTRIES];
predT       mDec;
predT       mEx;

// Results of the current cycle, valid after modelEval
logic mPredTaken;
logic mMispredict;
pcT   mRedirect;
pcT   mPredTarget;
logic mActualTaken;
pcT   mTargetE;

function automatic logic isJumpOp(input logic [6:0] op);
    return (op == OP_JAL) || (op == OP_JALR);
endfunction

task automatic modelReset();
    mPc = PC_START;
    mGhr = '0;
    mDec = '0;
    mEx = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        mBtbValid[i] = 1'b0;
        mBtbTag[i] = '0;
        mBtbTarget[i] = '0;
    end
    for (int i = 0; i < PHT_ENTRIES; i++) begin
        mPht[i] = CNT_RESET;
    end
endtask

task automatic modelEval(input instrT instr, input exInfoT ex);
    btbIdxT idx;
    logic   hit;
    idx = mPc[6:2];
    hit = mBtbValid[idx] && (mBtbTag[idx] == mPc[31:7]);
    mPredTarget = mBtbTarget[idx];
    mPredTaken = hit && (isJumpOp(instr[6:0]) ||
        ((instr[6:0] == OP_BRANCH) && mPht[mGhr][1]));
    // Execute slot outcome
    mActualTaken = (ex.op == OP_BRANCH) &&
        ((ex.funct3 == F3_BEQ && ex.zero) || (ex.funct3 == F3_BNE && !ex.zero));
    mTargetE = mEx.pc + ex.imm;
    mMispredict = mEx.valid && (((ex.op == OP_BRANCH) && (mEx.taken != mActualTaken)) ||
        (isJumpOp(ex.op) && !mEx.taken));
    mRedirect = mEx.taken ? mEx.pc + 32'd4 : mTargetE;
endtask

task automatic modelCommit(input instrT instr, input exInfoT ex, input logic stallF,
                           input logic stallD, input logic flushD, input logic flushE);
    btbIdxT     wIdx;
    logic [1:0] cnt;
    predT       fetchRec;
    if (mEx.valid && (mActualTaken || isJumpOp(ex.op))) begin
        wIdx = mEx.pc[6:2];
        mBtbValid[wIdx] = 1'b1;
        mBtbTag[wIdx] = mEx.pc[31:7];
        mBtbTarget[wIdx] = mTargetE;
    end
    // Saturating counter training
    if (mEx.valid && (ex.op == OP_BRANCH)) begin
        cnt = mPht[mEx.phtIdx];
        if (mActualTaken && cnt != 2'b11) begin
            cnt = cnt + 2'b01;
        end else if (!mActualTaken && cnt != 2'b00) begin
            cnt = cnt - 2'b01;
        end
        mPht[mEx.phtIdx] = cnt;
    end
    fetchRec.valid = 1'b1;
    fetchRec.taken = mPredTaken;
    fetchRec.pc = mPc;
    fetchRec.phtIdx = mGhr;
    if (mMispredict) begin
        mGhr = '0;
        mPc = mRedirect;
    end else if (!stallF) begin
        if (instr[6:0] == OP_BRANCH) begin
            mGhr = {mGhr[GHR_BITS-2:0], mPredTaken};
        end
        mPc = mPredTaken ? mPredTarget : mPc + 32'd4;
    end
    // Slots, execute first so it sees the old decode record
    if (flushE) begin
        mEx.valid = 1'b0;
    end else begin
        mEx = mDec;
    end
    if (flushD) begin
        mDec.valid = 1'b0;
    end else if (!stallD) begin
        mDec = fetchRec;
    end
endtask

`endif

// ==== dv/bpFrontEndTb.sv ====
// Testbench for the branch prediction front end
// LFSR stimulus, reference model comparison and timeout
`timescale 1ns/10ps

module bpFrontEndTb import bpPkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES = 3000;
    // Run length plus reset and a margin
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;

    logic   clk;
    logic   reset;
    instrT  instrF;
    logic   stallF;
    logic   stallD;
    logic   flushD;
    logic   flushE;
    exInfoT exInfo;
    pcT     pcF;
    logic   predTakenF;
    logic   mispredict;

    instrT       progTable [32];
    pcT          destTable [32];
    logic [15:0] lfsrQ;
    int          cycleCount = 0;
    int          mispredictCount = 0;
    int          predTakenCount = 0;

    `include "bpModel.svh"

    bpFrontEnd u_dut (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrF),
        .stallF_i     (stallF),
        .stallD_i     (stallD),
        .flushD_i     (flushD),
        .flushE_i     (flushE),
        .exInfo_i     (exInfo),
        .pcF_o        (pcF),
        .predTakenF_o (predTakenF),
        .mispredict_o (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrQ[15]};
            lfsrQ = lfsrStep(lfsrQ);
        end
    endtask

    task automatic failRun(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkPc(input string name, input pcT expected, input pcT actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            failRun("fetch PC mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            failRun("prediction flag mismatch");
        end
    endtask

    // Mix of branches, jumps and plain ALU ops with targets in the first 128 bytes
    task automatic buildTable();
        logic [31:0] kind;
        logic [31:0] dest;
        for (int i = 0; i < 32; i++) begin
            takeBits(3, kind);
            takeBits(5, dest);
            case (kind[2:0])
                3'd0, 3'd1, 3'd2: progTable[i] = {25'd0, OP_BRANCH};
                3'd3: progTable[i] = {25'd0, OP_JAL};
                3'd4: progTable[i] = {25'd0, OP_JALR};
                default: progTable[i] = {25'd0, 7'b0010011};
            endcase
            destTable[i] = {25'd0, dest[4:0], 2'b00};
        end
    endtask

    task automatic makeExInfo(output exInfoT ex);
        logic [31:0] bits;
        takeBits(2, bits);
        ex.op = progTable[mEx.pc[6:2]][6:0];
        ex.funct3 = bits[1] ? F3_BNE : F3_BEQ;
        ex.zero = bits[0];
        // Immediate lands the target on this entry's destination
        ex.imm = destTable[mEx.pc[6:2]] - mEx.pc;
    endtask

    // Each control at a rate of one in sixteen
    task automatic drawControls();
        logic [31:0] r;
        takeBits(16, r);
        stallF = (r[3:0] == 4'd0);
        stallD = (r[7:4] == 4'd0);
        flushD = (r[11:8] == 4'd0);
        flushE = (r[15:12] == 4'd0);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun("Simulation timed out before the run completed");
        end
    end

    initial begin
        instrT  instr;
        exInfoT ex;
        lfsrQ = 16'd94;
        reset = 1'b1;
        instrF = '0;
        stallF = 1'b0;
        stallD = 1'b0;
        flushD = 1'b0;
        flushE = 1'b0;
        exInfo = '0;
        buildTable();
        modelReset();
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset = 1'b0;
        checkPc("pcF_o", PC_START, pcF);
        checkFlag("predTakenF_o", 1'b0, predTakenF);
        checkFlag("mispredict_o", 1'b0, mispredict);
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            instr = progTable[mPc[6:2]];
            makeExInfo(ex);
            drawControls();
            instrF = instr;
            exInfo = ex;
            modelEval(instr, ex);
            // Outputs settle well before the falling edge
            @(negedge clk);
            checkPc("pcF_o", mPc, pcF);
            checkFlag("predTakenF_o", mPredTaken, predTakenF);
            checkFlag("mispredict_o", mMispredict, mispredict);
            mispredictCount += mMispredict ? 1 : 0;
            predTakenCount += mPredTaken ? 1 : 0;
            modelCommit(instr, ex, stallF, stallD, flushD, flushE);
            @(posedge clk);
            #0.5;
        end
        if (mispredictCount == 0 || predTakenCount == 0) begin
            failRun("Stimulus never produced both a taken prediction and a redirect");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+dv
design/bpPkg.sv
design/btb.sv
design/globalHistory.sv
design/branchResolve.sv
design/fetchPc.sv
design/bpFrontEnd.sv
dv/bpFrontEndTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" &&
    verilator --binary --assert --top-module bpFrontEndTb -f compile.f &&
    ./obj_dir/VbpFrontEndTb || exit 1
